// File: hdl/sig_match_macros.svh
`ifndef SIG_MATCH_MACROS_SVH
`define SIG_MATCH_MACROS_SVH

// Signature length in bytes
`define SM_SIG_LEN 7
// PRIVMSG with the first character in the top byte
`define SM_SIG_BYTES 56'h50_52_49_56_4D_53_47

// Ingress FIFO depth and the sender's starting credit count
`define SM_FIFO_DEPTH 8
// Number of tagged streams
`define SM_STREAMS 64
// Matcher state width
`define SM_STATE_W 11
// Idle cycles between the last byte and the eop pulse
`define SM_FLUSH_CYC 3

`endif

// File: hdl/sig_match_pkg.sv
`include "sig_match_macros.svh"

package sig_match_pkg;

  // Stream tag, wide enough for every stream
  typedef logic [$clog2(`SM_STREAMS)-1:0] stream_id_t;

  // Count of signature bytes matched so far
  // Upper bits stay zero for a short signature
  typedef logic [`SM_STATE_W-1:0] dfa_state_t;

  // One character of traffic
  typedef logic [7:0] byte_t;

endpackage

// File: hdl/sig_match_if.sv
`timescale 1ns/1ps

// Character stream from ingress into the context block
interface pkt_stream_if;
  sig_match_pkg::byte_t      chr;
  logic                      chr_vld;
  logic                      load_state;
  logic                      eop;
  sig_match_pkg::stream_id_t stream_id;
  logic                      new_stream;

  modport source (output chr, chr_vld, load_state, eop, stream_id, new_stream);
  modport sink   (input  chr, chr_vld, load_state, eop, stream_id, new_stream);
endinterface

// Registered matcher inputs and the matcher's results
interface dfa_port_if;
  sig_match_pkg::byte_t       chr;
  logic                       chr_vld;
  sig_match_pkg::dfa_state_t  state_in;
  logic                       state_vld;
  sig_match_pkg::dfa_state_t  state_out;
  logic                       accept;

  modport driver  (output chr, chr_vld, state_in, state_vld,
                   input  state_out, accept);
  modport matcher (input  chr, chr_vld, state_in, state_vld,
                   output state_out, accept);
endinterface

// File: hdl/sig_dfa.sv
`timescale 1ns/1ps
`include "sig_match_macros.svh"

module sig_dfa (
  input logic        clk,
  input logic        rst_n,
  dfa_port_if.matcher port
);

  localparam int LEN = `SM_SIG_LEN;
  localparam logic [8*`SM_SIG_LEN-1:0] SIG = `SM_SIG_BYTES;

  sig_match_pkg::dfa_state_t state;
  sig_match_pkg::dfa_state_t cur;
  logic                      accept;
  int                        nxt;

  // Signature byte i, counted from the first character
  function automatic sig_match_pkg::byte_t sig_at(input int i);
    return SIG[8*(LEN-1-i) +: 8];
  endfunction

  // Longest signature prefix ending the text sig[0..base-1] plus c
  // Limited to max_k bytes
  function automatic int prefix_fit(input int base,
                                    input sig_match_pkg::byte_t c,
                                    input int max_k);
    int   best;
    int   pos;
    logic ok;
    best = 0;
    for (int k = 1; k <= LEN; k++)
    begin
      ok = (k <= max_k) && (k <= base + 1);
      for (int j = 0; j < LEN; j++)
      begin
        // Position in the text that lines up with prefix byte j
        pos = base + 1 - k + j;
        if (ok && j < k)
        begin
          if (((pos < base) ? sig_at(pos) : c) != sig_at(j))
            ok = 1'b0;
        end
      end
      if (ok)
        best = k;
    end
    return best;
  endfunction

  // Where a full match resumes
  localparam int BORDER = prefix_fit(LEN - 1, sig_at(LEN - 1), LEN - 1);

  // A restored state replaces the held one before the step
  assign cur = port.state_vld ? port.state_in : state;

  always_comb
  begin
    // Advance on a hit, else KMP fallback to the longest live prefix
    nxt = prefix_fit(int'(cur), port.chr, LEN);
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      state  <= '0;
      accept <= 1'b0;
    end
    else
    begin
      accept <= 1'b0;
      if (port.chr_vld)
      begin
        if (nxt == LEN)
        begin
          accept <= 1'b1;
          state  <= sig_match_pkg::dfa_state_t'(BORDER);
        end
        else
          state <= sig_match_pkg::dfa_state_t'(nxt);
      end
      else if (port.state_vld)
        // Restore without a character just parks the state
        state <= port.state_in;
    end
  end

  assign port.state_out = state;
  assign port.accept    = accept;

  // Held state stays within the signature length
  a_state_range: assert property (@(posedge clk) disable iff (!rst_n)
    state <= LEN);

endmodule

// File: hdl/stream_context.sv
`timescale 1ns/1ps
`include "sig_match_macros.svh"

module stream_context (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        stream_en,
  pkt_stream_if.sink  pkt,
  dfa_port_if.driver  dfa,
  output logic        pkt_done,
  output logic        pkt_fired,
  output logic [15:0] match_count
);

  // Saved matcher state, one entry per stream
  sig_match_pkg::dfa_state_t state_mem [`SM_STREAMS];

  // Restored state, one cycle after load
  sig_match_pkg::dfa_state_t state_in;
  logic                      state_vld;

  // Register stage in front of the matcher
  sig_match_pkg::byte_t      chr_r;
  logic                      chr_vld_r;
  sig_match_pkg::dfa_state_t state_in_r;
  logic                      state_vld_r;

  // Register stage behind the matcher
  sig_match_pkg::dfa_state_t state_out_r;
  logic                      accept_r;

  // Set on any accept within the current packet
  logic                      match_flag;

  // State memory write port
  always_ff @(posedge clk)
  begin
    if (pkt.eop && stream_en)
      // Enabled packet leaves its state for the next one
      state_mem[pkt.stream_id] <= state_out_r;
    else if (pkt.load_state && pkt.new_stream)
      // First sight of a stream starts its entry from zero
      state_mem[pkt.stream_id] <= '0;
  end

  // Restore path
  always_ff @(posedge clk)
  begin
    if (pkt.load_state)
      state_in <= pkt.new_stream ? '0 : state_mem[pkt.stream_id];
  end

  // Payload side of both register stages
  always_ff @(posedge clk)
  begin
    chr_r       <= pkt.chr;
    state_in_r  <= state_in;
    state_out_r <= dfa.state_out;
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      state_vld   <= 1'b0;
      chr_vld_r   <= 1'b0;
      state_vld_r <= 1'b0;
      accept_r    <= 1'b0;
      match_flag  <= 1'b0;
      pkt_done    <= 1'b0;
      pkt_fired   <= 1'b0;
      match_count <= '0;
    end
    else
    begin
      state_vld   <= pkt.load_state;
      chr_vld_r   <= pkt.chr_vld;
      state_vld_r <= state_vld;
      accept_r    <= dfa.accept;
      pkt_done    <= pkt.eop;
      pkt_fired   <= pkt.eop && stream_en && match_flag;
      // New packet starts with no match
      if (pkt.load_state)
        match_flag <= 1'b0;
      if (accept_r)
        match_flag <= 1'b1;
      // Final count at end of packet
      if (pkt.eop)
      begin
        if (stream_en)
          match_count <= match_count + 16'(match_flag);
        else
          match_flag <= 1'b0;
      end
    end
  end

  // Matcher sees only registered inputs
  assign dfa.chr       = chr_r;
  assign dfa.chr_vld   = chr_vld_r;
  assign dfa.state_in  = state_in_r;
  assign dfa.state_vld = state_vld_r;

  // Ingress flush gap must drain every character and accept before eop
  a_eop_drained: assert property (@(posedge clk) disable iff (!rst_n)
    pkt.eop |-> !chr_vld_r && !accept_r);

endmodule

// File: hdl/stream_config.sv
`timescale 1ns/1ps
`include "sig_match_macros.svh"

module stream_config (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      cfg_wr,
  input  sig_match_pkg::stream_id_t cfg_stream,
  input  logic                      cfg_en,
  input  sig_match_pkg::stream_id_t cur_stream,
  output logic                      stream_en
);

  // One enable bit per stream
  logic [`SM_STREAMS-1:0] en_bits;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
      // All streams start disabled
      en_bits <= '0;
    else if (cfg_wr)
      en_bits[cfg_stream] <= cfg_en;
  end

  // Enable for whatever stream the context is working on
  assign stream_en = en_bits[cur_stream];

endmodule

// File: hdl/pkt_ingress.sv
`timescale 1ns/1ps
`include "sig_match_macros.svh"

module pkt_ingress (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      in_vld,
  input  sig_match_pkg::byte_t      in_byte,
  input  logic                      in_sop,
  input  logic                      in_eop,
  input  sig_match_pkg::stream_id_t in_stream,
  output logic                      credit_ret,
  pkt_stream_if.source              pkt
);

  localparam int PTR_W = $clog2(`SM_FIFO_DEPTH);
  localparam int CNT_W = $clog2(`SM_FLUSH_CYC + 1);

  // Sequencer states
  localparam logic [1:0] ST_IDLE  = 2'd0;
  localparam logic [1:0] ST_DATA  = 2'd1;
  localparam logic [1:0] ST_FLUSH = 2'd2;

  // FIFO storage, one slot per outstanding credit
  sig_match_pkg::byte_t      fifo_byte [`SM_FIFO_DEPTH];
  logic                      fifo_sop  [`SM_FIFO_DEPTH];
  logic                      fifo_eop  [`SM_FIFO_DEPTH];
  sig_match_pkg::stream_id_t fifo_sid  [`SM_FIFO_DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   fill;
  logic             full;
  logic             empty;
  logic             pop;
  logic             start_pkt;

  logic [1:0]       seq_st;
  logic [CNT_W-1:0] flush_cnt;

  // Streams seen since reset
  logic [`SM_STREAMS-1:0] seen;

  assign full  = (fill == (PTR_W+1)'(`SM_FIFO_DEPTH));
  assign empty = (fill == '0);

  // Head of FIFO opens a packet, so a load cycle goes first
  assign start_pkt = (seq_st == ST_IDLE) && !empty && fifo_sop[rd_ptr];

  always_comb
  begin
    case (seq_st)
      // Stray byte outside any packet is dropped
      ST_IDLE: pop = !empty && !fifo_sop[rd_ptr];
      ST_DATA: pop = !empty;
      default: pop = 1'b0;
    endcase
  end

  // FIFO write side and payload outputs
  always_ff @(posedge clk)
  begin
    if (in_vld)
    begin
      fifo_byte[wr_ptr] <= in_byte;
      fifo_sop[wr_ptr]  <= in_sop;
      fifo_eop[wr_ptr]  <= in_eop;
      fifo_sid[wr_ptr]  <= in_stream;
    end
    if (pop)
      pkt.chr <= fifo_byte[rd_ptr];
    if (start_pkt)
    begin
      // Tag held for the whole packet up to its eop
      pkt.stream_id  <= fifo_sid[rd_ptr];
      pkt.new_stream <= !seen[fifo_sid[rd_ptr]];
    end
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      wr_ptr         <= '0;
      rd_ptr         <= '0;
      fill           <= '0;
      seq_st         <= ST_IDLE;
      flush_cnt      <= '0;
      seen           <= '0;
      credit_ret     <= 1'b0;
      pkt.load_state <= 1'b0;
      pkt.chr_vld    <= 1'b0;
      pkt.eop        <= 1'b0;
    end
    else
    begin
      if (in_vld)
        wr_ptr <= wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;
      fill <= fill + (PTR_W+1)'(in_vld) - (PTR_W+1)'(pop);
      // Every pop hands one credit back to the sender
      credit_ret     <= pop;
      pkt.chr_vld    <= pop && (seq_st == ST_DATA);
      pkt.load_state <= start_pkt;
      pkt.eop        <= 1'b0;
      case (seq_st)
        ST_IDLE:
        begin
          if (start_pkt)
          begin
            seen[fifo_sid[rd_ptr]] <= 1'b1;
            seq_st <= ST_DATA;
          end
        end
        ST_DATA:
        begin
          // Last byte leaves, then the pipeline drains
          if (pop && fifo_eop[rd_ptr])
          begin
            flush_cnt <= '0;
            seq_st    <= ST_FLUSH;
          end
        end
        default:
        begin
          if (flush_cnt == CNT_W'(`SM_FLUSH_CYC))
          begin
            pkt.eop <= 1'b1;
            seq_st  <= ST_IDLE;
          end
          else
            flush_cnt <= flush_cnt + 1'b1;
        end
      endcase
    end
  end

  // Sender must not push past its credits
  a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
    in_vld |-> !full);

  // Load cycle always stands alone ahead of the first character
  a_load_alone: assert property (@(posedge clk) disable iff (!rst_n)
    !(pkt.chr_vld && pkt.load_state));

endmodule

// File: hdl/sig_match_top.sv
`timescale 1ns/1ps

module sig_match_top (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      in_vld,
  input  sig_match_pkg::byte_t      in_byte,
  input  logic                      in_sop,
  input  logic                      in_eop,
  input  sig_match_pkg::stream_id_t in_stream,
  input  logic                      cfg_wr,
  input  sig_match_pkg::stream_id_t cfg_stream,
  input  logic                      cfg_en,
  output logic                      credit_ret,
  output logic                      pkt_done,
  output logic                      pkt_fired,
  output logic [15:0]               match_count
);

  // Ingress to context
  pkt_stream_if pkt_bus ();
  // Context to matcher
  dfa_port_if   dfa_bus ();

  // Enable bit for the stream now in the context
  logic stream_en;

  pkt_ingress u_ingress (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_vld     (in_vld),
    .in_byte    (in_byte),
    .in_sop     (in_sop),
    .in_eop     (in_eop),
    .in_stream  (in_stream),
    .credit_ret (credit_ret),
    .pkt        (pkt_bus.source)
  );

  stream_config u_config (
    .clk        (clk),
    .rst_n      (rst_n),
    .cfg_wr     (cfg_wr),
    .cfg_stream (cfg_stream),
    .cfg_en     (cfg_en),
    .cur_stream (pkt_bus.stream_id),
    .stream_en  (stream_en)
  );

  stream_context u_context (
    .clk         (clk),
    .rst_n       (rst_n),
    .stream_en   (stream_en),
    .pkt         (pkt_bus.sink),
    .dfa         (dfa_bus.driver),
    .pkt_done    (pkt_done),
    .pkt_fired   (pkt_fired),
    .match_count (match_count)
  );

  sig_dfa u_dfa (
    .clk   (clk),
    .rst_n (rst_n),
    .port  (dfa_bus.matcher)
  );

endmodule

// File: dv/sig_match_tb.sv
`timescale 1ns/1ps
`include "sig_match_macros.svh"

module sig_match_tb;

  localparam int    WAIT_LIMIT = 500;
  localparam string SIG        = "PRIVMSG";

  logic                      clk;
  logic                      rst_n;
  logic                      in_vld;
  sig_match_pkg::byte_t      in_byte;
  logic                      in_sop;
  logic                      in_eop;
  sig_match_pkg::stream_id_t in_stream;
  logic                      cfg_wr;
  sig_match_pkg::stream_id_t cfg_stream;
  logic                      cfg_en;
  logic                      credit_ret;
  logic                      pkt_done;
  logic                      pkt_fired;
  logic [15:0]               match_count;

  int     errors;
  int     timeouts;
  string  test_name;
  integer seed;

  // Credit and packet bookkeeping
  int sent_total;
  int ret_total;
  int pkts_sent;
  int done_total;

  // Reference model: matched prefix and enable per stream
  int          saved_st [`SM_STREAMS];
  bit          en_model [`SM_STREAMS];
  int          model_count;
  bit          exp_fired_arr [256];
  logic [15:0] exp_count_arr [256];
  logic        cur_exp_fired;
  logic [15:0] cur_exp_count;

  // Bytes of the packet being built
  sig_match_pkg::byte_t pkt_q [$];
  int                   burst_ids [5] = '{3, 9, 12, 20, 5};

  sig_match_top UUT (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_vld      (in_vld),
    .in_byte     (in_byte),
    .in_sop      (in_sop),
    .in_eop      (in_eop),
    .in_stream   (in_stream),
    .cfg_wr      (cfg_wr),
    .cfg_stream  (cfg_stream),
    .cfg_en      (cfg_en),
    .credit_ret  (credit_ret),
    .pkt_done    (pkt_done),
    .pkt_fired   (pkt_fired),
    .match_count (match_count)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Returned credits and finished packets, counted on the clock
  always @(posedge clk)
  begin
    if (credit_ret)
      ret_total++;
    if (pkt_done)
      done_total++;
  end

  // Expectation for the packet whose pkt_done comes next
  assign cur_exp_fired = exp_fired_arr[done_total];
  assign cur_exp_count = exp_count_arr[done_total];

  a_reset_clear: assert property (@(posedge clk)
    $rose(rst_n) |-> (match_count == 16'd0) && !pkt_done)
    else
    begin
      errors++;
      $display("ERROR reset: match_count/pkt_done expected 0/0 actual %0d/%0b",
               $sampled(match_count), $sampled(pkt_done));
    end

  a_fired: assert property (@(posedge clk) disable iff (!rst_n)
    pkt_done |-> (pkt_fired == cur_exp_fired))
    else
    begin
      errors++;
      $display("ERROR %s: pkt_fired expected %0b actual %0b", test_name,
               $sampled(cur_exp_fired), $sampled(pkt_fired));
    end

  a_count: assert property (@(posedge clk) disable iff (!rst_n)
    pkt_done |-> (match_count == cur_exp_count))
    else
    begin
      errors++;
      $display("ERROR %s: match_count expected %0d actual %0d", test_name,
               $sampled(cur_exp_count), $sampled(match_count));
    end

  a_done_owed: assert property (@(posedge clk) disable iff (!rst_n)
    pkt_done |-> (done_total < pkts_sent))
    else
    begin
      errors++;
      $display("%s: pkt_done came with no packet outstanding", test_name);
    end

  // P occurs once in the signature, so a miss can only restart on P
  function automatic int next_state(input int st, input sig_match_pkg::byte_t c);
    if (c == SIG[st])
      return st + 1;
    if (c == SIG[0])
      return 1;
    return 0;
  endfunction

  task automatic add_text(input string s);
    for (int i = 0; i < s.len(); i++)
      pkt_q.push_back(s[i]);
  endtask

  // Random filler that never opens a partial match
  task automatic add_filler(input int n);
    logic [31:0] r;
    for (int i = 0; i < n; i++)
    begin
      do
        r = $random(seed);
      while (r[7:0] == "P");
      pkt_q.push_back(r[7:0]);
    end
  endtask

  task automatic set_enable(input sig_match_pkg::stream_id_t sid, input bit en);
    cfg_wr     = 1'b1;
    cfg_stream = sid;
    cfg_en     = en;
    en_model[sid] = en;
    @(posedge clk);
    #1;
    cfg_wr = 1'b0;
  endtask

  task automatic send_byte(input sig_match_pkg::byte_t b, input bit sop, input bit eop,
                           input sig_match_pkg::stream_id_t sid);
    int waited;
    waited = 0;
    // Hold off while the sender has no credit left
    while ((`SM_FIFO_DEPTH - sent_total + ret_total) <= 0 && waited < WAIT_LIMIT)
    begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (waited >= WAIT_LIMIT)
    begin
      timeouts++;
      $display("Timeout in %s: no credit came back to the sender", test_name);
    end
    else
    begin
      in_vld    = 1'b1;
      in_byte   = b;
      in_sop    = sop;
      in_eop    = eop;
      in_stream = sid;
      sent_total++;
      @(posedge clk);
      #1;
      in_vld = 1'b0;
      in_sop = 1'b0;
      in_eop = 1'b0;
    end
  endtask

  // Predict the packet from the model, then put it on the wire
  task automatic send_packet(input sig_match_pkg::stream_id_t sid);
    int st;
    bit hit;
    bit fired;
    st  = saved_st[sid];
    hit = 1'b0;
    foreach (pkt_q[i])
    begin
      st = next_state(st, pkt_q[i]);
      // Full match, PRIVMSG has no border so matching resumes at zero
      if (st == `SM_SIG_LEN)
      begin
        hit = 1'b1;
        st  = 0;
      end
    end
    fired = en_model[sid] && hit;
    if (en_model[sid])
    begin
      saved_st[sid] = st;
      model_count  += fired;
    end
    exp_fired_arr[pkts_sent] = fired;
    exp_count_arr[pkts_sent] = 16'(model_count);
    pkts_sent++;
    foreach (pkt_q[i])
      send_byte(pkt_q[i], i == 0, i == pkt_q.size() - 1, sid);
    pkt_q.delete();
  endtask

  task automatic wait_all_done();
    int waited;
    waited = 0;
    while (done_total < pkts_sent && waited < WAIT_LIMIT)
    begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (done_total < pkts_sent)
    begin
      timeouts++;
      $display("Timeout in %s: %0d packet(s) never reported pkt_done", test_name,
               pkts_sent - done_total);
    end
  endtask

  initial
  begin
    int          ret_start;
    int          mode;
    logic [31:0] r;
    in_vld      = 1'b0;
    in_byte     = '0;
    in_sop      = 1'b0;
    in_eop      = 1'b0;
    in_stream   = '0;
    cfg_wr      = 1'b0;
    cfg_stream  = '0;
    cfg_en      = 1'b0;
    errors      = 0;
    timeouts    = 0;
    model_count = 0;
    seed        = 32'hacfbc66f;
    test_name   = "reset";
    rst_n       = 1'b0;
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // More bytes than credits, on a disabled stream
    test_name = "reset_credits";
    ret_start = ret_total;
    add_filler(20);
    send_packet(1);
    wait_all_done();
    assert (ret_total - ret_start == 20)
    else
    begin
      errors++;
      $display("ERROR %s: credit_ret pulses expected 20 actual %0d", test_name,
               ret_total - ret_start);
    end

    test_name = "single_match";
    set_enable(3, 1'b1);
    add_filler(3);
    add_text(SIG);
    add_filler(2);
    send_packet(3);
    wait_all_done();

    test_name = "disabled_stream";
    add_filler(3);
    add_text(SIG);
    add_filler(2);
    send_packet(5);
    wait_all_done();

    // Signature split over two packets of stream 3
    test_name = "split_packets";
    add_filler(4);
    add_text("PRIV");
    send_packet(3);
    add_text("MSG");
    add_filler(3);
    send_packet(3);
    wait_all_done();

    // Stream 3 left at PRI while a new stream sees MSG
    test_name = "new_stream_clean";
    set_enable(9, 1'b1);
    add_filler(2);
    add_text("PRI");
    send_packet(3);
    add_text("MSG");
    add_filler(4);
    send_packet(9);
    wait_all_done();

    test_name = "credit_burst";
    set_enable(12, 1'b1);
    set_enable(20, 1'b1);
    for (int k = 0; k < 16; k++)
    begin
      r    = $random(seed);
      mode = r[2:0] % 5;
      case (mode)
        0: add_filler(6);
        1:
        begin
          add_filler(int'(r[5:4]) + 1);
          add_text(SIG);
          add_filler(2);
        end
        2:
        begin
          add_filler(3);
          add_text("PRIV");
        end
        3:
        begin
          add_text("MSG");
          add_filler(4);
        end
        default:
        begin
          // Two hits in one packet still count once
          add_text(SIG);
          add_text(SIG);
        end
      endcase
      send_packet(burst_ids[r[10:8] % 5]);
    end
    wait_all_done();
    repeat (4) @(posedge clk);

    test_name = "final";
    assert (ret_total == sent_total)
    else
    begin
      errors++;
      $display("ERROR %s: credits returned expected %0d actual %0d", test_name,
               sent_total, ret_total);
    end

    $display("Checked %0d packets: %0d errors, %0d timeouts", done_total, errors, timeouts);
    if (errors == 0 && timeouts == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

endmodule

// File: sig_match_top.f
+incdir+hdl
hdl/sig_match_pkg.sv
hdl/sig_match_if.sv
hdl/sig_dfa.sv
hdl/stream_context.sv
hdl/stream_config.sv
hdl/pkt_ingress.sv
hdl/sig_match_top.sv
dv/sig_match_tb.sv
